// File: build.f
+incdir+design
design/rdmx_pkg.sv
design/md_capture.sv
design/frame_sequencer.sv
design/axi_write_driver.sv
design/rdmx_shim.sv
testbench/tb_rdmx_shim.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rdmx_shim
RTL_TOP   := rdmx_shim
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The log search decides the exit status
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/tb_rdmx_shim.sv
// Testbench for the frame-streaming shim with table-driven cases checked against a write model
`timescale 1ns/1ps

module tb_rdmx_shim;
    import rdmx_pkg::*;

    localparam int    LIMIT   = 5000;
    localparam addr_t FD_BASE = 64'h0000_0000_1000_0000;
    localparam addr_t MD_BASE = 64'h0000_0000_2000_0000;
    localparam addr_t FC_ADDR = 64'h0000_0000_3000_0040;

    // One case with ring sizes picked so both offsets wrap
    typedef struct {
        int unsigned pkt;
        int unsigned frame;
        addr_t       fd_size;
        addr_t       md_size;
        int          frames;
        int          stall;
    } case_t;

    logic        clk = 1'b0;
    logic        resetn;
    shim_cfg_t   cfg;
    fd_beat_t    fd;
    logic        fd_valid;
    logic        fd_ready;
    data_t       md_data;
    logic        md_valid;
    logic        md_ready;
    aw_req_t     aw;
    logic        aw_valid;
    w_beat_t     w;
    logic        w_valid;
    logic        w_ready = 1'b0;
    logic [31:0] frame_count;
    logic        eof;

    case_t  cases [4];
    integer seed = 32'h55bf_9c1f;
    int     stall_pct = 0;
    int     err_data = 0;
    int     err_order = 0;
    int     err_flow = 0;
    int     n_w = 0;
    int     n_aw = 0;
    int     eof_cnt;
    int     md_cnt;
    logic   md_pend;
    logic   burst_open;

    // Source streams and predicted writes
    fd_beat_t fd_q[$];
    data_t    md_q[$];
    aw_req_t  exp_aw[$];
    w_beat_t  exp_w[$];
    logic     exp_md2[$];

    rdmx_shim i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .fd          (fd),
        .fd_valid    (fd_valid),
        .fd_ready    (fd_ready),
        .md_data     (md_data),
        .md_valid    (md_valid),
        .md_ready    (md_ready),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .frame_count (frame_count),
        .eof         (eof)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Random slave back-pressure
    always @(posedge clk) begin : stall_gen
        int unsigned roll;
        roll = $unsigned($random(seed));
        w_ready <= int'(roll % 100) >= stall_pct;
    end

    // Packets between metadata records with an even split only for power-of-two sizes
    function automatic int unsigned half_frame_packets(input int unsigned ps,
                                                       input int unsigned fs);
        if (ps >= 64 && ps <= 8192 && (ps & (ps - 1)) == 0) begin
            return fs / ps / 2;
        end
        return 1;
    endfunction

    function automatic void predict_aw(input addr_t a, input int unsigned len);
        aw_req_t e;
        e.addr = a;
        e.len  = 8'(len);
        exp_aw.push_back(e);
    endfunction

    function automatic void predict_w(input data_t d, input strb_t s, input logic l,
                                      input logic md2);
        w_beat_t e;
        e.data = d;
        e.strb = s;
        e.last = l;
        exp_w.push_back(e);
        exp_md2.push_back(md2);
    endfunction

    // ---------------------------------------------------------------------------
    // Monitor samples mid-cycle where all handshakes are settled
    // ---------------------------------------------------------------------------
    always @(negedge clk) begin : monitor
        w_beat_t ew;
        aw_req_t ea;
        logic    was_md2;
        logic    exp_first;
        if (!resetn) begin
            eof_cnt    = 0;
            md_cnt     = 0;
            md_pend    = 1'b0;
            burst_open = 1'b0;
        end else begin
            exp_first = 1'b0;
            if (fd_ready && !w_ready) begin
                $display("error: t=%0t fd_ready high while w_ready low", $time);
                err_data++;
            end
            // Held record must block the stream until it has been written
            if (md_pend && md_ready) begin
                $display("error: t=%0t md_ready high before metadata was written", $time);
                err_data++;
            end
            if (w_valid && w_ready) begin
                n_w++;
                // A beat after a last flag opens a new burst
                exp_first  = !burst_open;
                burst_open = !w.last;
                if (exp_w.size() == 0) begin
                    $display("Write data beat at %0t was not predicted by the model", $time);
                    err_order++;
                end else begin
                    ew      = exp_w.pop_front();
                    was_md2 = exp_md2.pop_front();
                    if (w !== ew) begin
                        $display("error: t=%0t w beat got %h expected %h", $time, w, ew);
                        err_data++;
                    end
                    if (was_md2) begin
                        md_pend = 1'b0;
                    end
                end
            end
            // Address goes out exactly with the accepted first beat of a burst
            if (aw_valid !== exp_first) begin
                $display("error: t=%0t aw_valid %b expected %b", $time, aw_valid, exp_first);
                err_order++;
            end
            if (aw_valid) begin
                n_aw++;
                if (exp_aw.size() == 0) begin
                    $display("Write address at %0t was not predicted by the model", $time);
                    err_order++;
                end else begin
                    ea = exp_aw.pop_front();
                    if (aw !== ea) begin
                        $display("error: t=%0t aw got %h expected %h", $time, aw, ea);
                        err_data++;
                    end
                end
            end
            if (md_valid && md_ready) begin
                md_cnt++;
                if (md_cnt == 2) begin
                    md_cnt  = 0;
                    md_pend = 1'b1;
                end
            end
            if (eof) begin
                eof_cnt++;
                if (frame_count !== 32'(eof_cnt)) begin
                    $display("error: t=%0t frame_count %0d at eof %0d", $time,
                             frame_count, eof_cnt);
                    err_data++;
                end
            end
        end
    end

    // Reset, then check the quiet outputs through reset and the idle/start cycles
    task automatic apply_reset();
        int i;
        resetn   <= 1'b0;
        fd_valid <= 1'b0;
        md_valid <= 1'b0;
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            if (i == 9) begin
                resetn <= 1'b1;
            end
            @(negedge clk);
            if (w_valid || aw_valid || fd_ready || eof) begin
                $display("error: t=%0t output active in reset or start-up", $time);
                err_flow++;
            end
            if (resetn && !md_ready) begin
                $display("error: t=%0t md_ready low after reset", $time);
                err_flow++;
            end
        end
        @(posedge clk);
    endtask

    task automatic drive_fd();
        int guard;
        while (fd_q.size() > 0) begin
            fd       <= fd_q[0];
            fd_valid <= 1'b1;
            guard = 0;
            @(posedge clk);
            while (!(fd_valid && fd_ready) && guard < LIMIT) begin
                @(posedge clk);
                guard++;
            end
            if (guard >= LIMIT) begin
                $display("Timed out waiting for fd_ready at %0t", $time);
                err_flow++;
                fd_q.delete();
            end else begin
                void'(fd_q.pop_front());
            end
        end
        fd_valid <= 1'b0;
    endtask

    task automatic drive_md();
        int guard;
        while (md_q.size() > 0) begin
            md_data  <= md_q[0];
            md_valid <= 1'b1;
            guard = 0;
            @(posedge clk);
            while (!(md_valid && md_ready) && guard < LIMIT) begin
                @(posedge clk);
                guard++;
            end
            if (guard >= LIMIT) begin
                $display("Timed out waiting for md_ready at %0t", $time);
                err_flow++;
                md_q.delete();
            end else begin
                void'(md_q.pop_front());
            end
        end
        md_valid <= 1'b0;
    endtask

    // ---------------------------------------------------------------------------
    // One case with model build, reset, stimulus and drain
    // ---------------------------------------------------------------------------
    task automatic run_case(input int idx);
        case_t       c;
        int unsigned pph;
        int unsigned beats;
        addr_t       fd_off;
        addr_t       md_off;
        data_t       d;
        int          f;
        int          p;
        int          b;
        int          guard;
        c      = cases[idx];
        pph    = half_frame_packets(c.pkt, c.frame);
        beats  = c.pkt / 8;
        fd_off = '0;
        md_off = '0;
        fd_q.delete();
        md_q.delete();
        exp_aw.delete();
        exp_w.delete();
        exp_md2.delete();
        for (f = 1; f <= c.frames; f++) begin
            // Half-frame of packets, one burst each
            for (p = 0; p < int'(pph); p++) begin
                predict_aw(FD_BASE + fd_off, beats - 1);
                for (b = 0; b < int'(beats); b++) begin
                    d[63:32] = $random(seed);
                    d[31:0]  = $random(seed);
                    fd_q.push_back({d, b == int'(beats) - 1});
                    predict_w(d, 8'hff, b == int'(beats) - 1, 1'b0);
                end
                fd_off = (fd_off + addr_t'(c.pkt) < c.fd_size) ? fd_off + addr_t'(c.pkt) : '0;
            end
            // Two-beat metadata record under one address
            predict_aw(MD_BASE + md_off, 1);
            for (b = 0; b < 2; b++) begin
                d[63:32] = $random(seed);
                d[31:0]  = $random(seed);
                md_q.push_back(d);
                predict_w(d, 8'hff, b == 1, b == 1);
            end
            md_off = (md_off + 64'd16 < c.md_size) ? md_off + 64'd16 : '0;
            // Frame counter, numbered from 1
            predict_aw(FC_ADDR, 0);
            predict_w(data_t'(f), 8'h0f, 1'b1, 1'b0);
        end
        stall_pct              <= c.stall;
        cfg.packet_size        <= 16'(c.pkt);
        cfg.frame_size         <= c.frame;
        cfg.fd_ring.base       <= FD_BASE;
        cfg.fd_ring.size       <= c.fd_size;
        cfg.md_ring.base       <= MD_BASE;
        cfg.md_ring.size       <= c.md_size;
        cfg.fc_addr            <= FC_ADDR;
        apply_reset();
        fork
            drive_fd();
            drive_md();
        join
        guard = 0;
        while ((eof_cnt < c.frames || exp_w.size() != 0) && guard < LIMIT) begin
            @(posedge clk);
            guard++;
        end
        if (guard >= LIMIT) begin
            $display("Case %0d timed out before all frames were written", idx);
            err_flow++;
        end
        if (eof_cnt != c.frames || exp_aw.size() != 0 || exp_w.size() != 0) begin
            $display("error: t=%0t case %0d eof %0d of %0d, %0d aw and %0d w left over",
                     $time, idx, eof_cnt, c.frames, exp_aw.size(), exp_w.size());
            err_flow++;
        end
    endtask

    initial begin
        int i;
        resetn   <= 1'b0;
        cfg      <= '0;
        fd       <= '0;
        fd_valid <= 1'b0;
        md_data  <= '0;
        md_valid <= 1'b0;
        // packet, frame, fd ring, md ring, frames, stall percent
        cases[0] = '{64, 512, 64'd192, 64'd32, 3, 0};
        cases[1] = '{128, 1024, 64'd384, 64'd40, 4, 30};
        cases[2] = '{24, 96, 64'd72, 64'd16, 4, 50};
        cases[3] = '{256, 1024, 64'd512, 64'd32, 3, 20};
        for (i = 0; i < 4; i++) begin
            run_case(i);
        end
        $display("w beats %0d, aw %0d, errors data %0d order %0d flow %0d",
                 n_w, n_aw, err_data, err_order, err_flow);
        if (err_data + err_order + err_flow == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/rdmx_shim.sv
// Frame-streaming shim top, stream packets and metadata into AXI write rings
`timescale 1ns/1ps
`include "rdmx_settings.svh"

module rdmx_shim (
    input  logic                 clk,
    input  logic                 resetn,
    input  rdmx_pkg::shim_cfg_t  cfg,
    input  rdmx_pkg::fd_beat_t   fd,
    input  logic                 fd_valid,
    output logic                 fd_ready,
    input  rdmx_pkg::data_t      md_data,
    input  logic                 md_valid,
    output logic                 md_ready,
    output rdmx_pkg::aw_req_t    aw,
    output logic                 aw_valid,
    output rdmx_pkg::w_beat_t    w,
    output logic                 w_valid,
    input  logic                 w_ready,
    output logic [31:0]          frame_count,
    output logic                 eof
);
    import rdmx_pkg::*;

    // Metadata record handoff
    logic                           md_full;
    logic                           md_release;
    data_t [`RDMX_MD_BEATS-1:0]     md_beats;

    // Sequencer to driver
    out_mode_t                      mode;
    addr_t                          fd_offset;
    addr_t                          md_offset;
    logic                           first_beat;

    // Driver back to sequencer
    logic                           w_fire;
    logic                           w_last;

    // ---------------------------------------------------------------------------
    // Input side
    // ---------------------------------------------------------------------------
    md_capture i_md_capture (
        .clk        (clk),
        .resetn     (resetn),
        .md_data    (md_data),
        .md_valid   (md_valid),
        .md_ready   (md_ready),
        .md_release (md_release),
        .md_full    (md_full),
        .md_beats   (md_beats)
    );

    // ---------------------------------------------------------------------------
    // Frame control
    // ---------------------------------------------------------------------------
    frame_sequencer i_frame_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .w_fire      (w_fire),
        .w_last      (w_last),
        .md_full     (md_full),
        .mode        (mode),
        .fd_offset   (fd_offset),
        .md_offset   (md_offset),
        .first_beat  (first_beat),
        .md_release  (md_release),
        .frame_count (frame_count),
        .eof         (eof)
    );

    // ---------------------------------------------------------------------------
    // Output side
    // ---------------------------------------------------------------------------
    axi_write_driver i_axi_write_driver (
        .mode        (mode),
        .cfg         (cfg),
        .fd_offset   (fd_offset),
        .md_offset   (md_offset),
        .first_beat  (first_beat),
        .md_full     (md_full),
        .md_beats    (md_beats),
        .frame_count (frame_count),
        .fd          (fd),
        .fd_valid    (fd_valid),
        .fd_ready    (fd_ready),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_fire      (w_fire),
        .w_last      (w_last)
    );

endmodule

// File: design/axi_write_driver.sv
// Write channel driver that steers frame data, metadata or frame counter onto AW and W
`timescale 1ns/1ps
`include "rdmx_settings.svh"

module axi_write_driver (
    input  rdmx_pkg::out_mode_t                   mode,
    input  rdmx_pkg::shim_cfg_t                   cfg,
    input  rdmx_pkg::addr_t                       fd_offset,
    input  rdmx_pkg::addr_t                       md_offset,
    input  logic                                  first_beat,
    input  logic                                  md_full,
    input  rdmx_pkg::data_t [`RDMX_MD_BEATS-1:0]  md_beats,
    input  logic [31:0]                           frame_count,
    input  rdmx_pkg::fd_beat_t                    fd,
    input  logic                                  fd_valid,
    output logic                                  fd_ready,
    output rdmx_pkg::aw_req_t                     aw,
    output logic                                  aw_valid,
    output rdmx_pkg::w_beat_t                     w,
    output logic                                  w_valid,
    input  logic                                  w_ready,
    output logic                                  w_fire,
    output logic                                  w_last
);
    import rdmx_pkg::*;

    localparam int BEAT_BYTES = `RDMX_DATA_WBITS / 8;
    localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);

    logic [15:0] pkt_beats;
    strb_t       fc_strb;

    // Beats per frame-data packet
    assign pkt_beats = cfg.packet_size >> BEAT_SHIFT;
    // Frame counter covers the low bytes only
    assign fc_strb   = {{(BEAT_BYTES - `RDMX_FC_BYTES){1'b0}}, {`RDMX_FC_BYTES{1'b1}}};

    // ---------------------------------------------------------------------------
    // W channel
    // ---------------------------------------------------------------------------
    always_comb begin
        w       = '0;
        w_valid = 1'b0;
        case (mode)
            OM_FD: begin
                // Straight pass-through from the stream
                w.data  = fd.data;
                w.strb  = '1;
                w.last  = fd.last;
                w_valid = fd_valid;
            end
            OM_MD1: begin
                w.data  = md_beats[0];
                w.strb  = '1;
                w_valid = md_full;
            end
            OM_MD2: begin
                w.data  = md_beats[1];
                w.strb  = '1;
                w.last  = 1'b1;
                w_valid = md_full;
            end
            OM_FC: begin
                w.data  = data_t'(frame_count);
                w.strb  = fc_strb;
                w.last  = 1'b1;
                w_valid = 1'b1;
            end
            default: ;
        endcase
    end

    // Stream moves only when the slave takes the beat
    assign fd_ready = (mode == OM_FD) && w_ready;
    assign w_fire   = w_valid && w_ready;
    assign w_last   = w.last;

    // ---------------------------------------------------------------------------
    // AW channel
    // ---------------------------------------------------------------------------
    always_comb begin
        aw = '0;
        case (mode)
            OM_FD: begin
                aw.addr = cfg.fd_ring.base + fd_offset;
                aw.len  = 8'(pkt_beats - 16'd1);
            end
            OM_MD1, OM_MD2: begin
                // Both halves share the record address
                aw.addr = cfg.md_ring.base + md_offset;
                aw.len  = 8'(`RDMX_MD_BEATS - 1);
            end
            OM_FC: begin
                aw.addr = cfg.fc_addr;
                aw.len  = 8'd0;
            end
            default: ;
        endcase
    end

    // One-cycle announcement on the accepted first beat of each burst
    assign aw_valid = w_fire && first_beat && (mode inside {OM_FD, OM_MD1, OM_FC});

endmodule

// File: design/frame_sequencer.sv
// Frame sequencer FSM that walks the packets, metadata and frame counter of each frame
`timescale 1ns/1ps
`include "rdmx_settings.svh"

module frame_sequencer (
    input  logic                 clk,
    input  logic                 resetn,
    input  rdmx_pkg::shim_cfg_t  cfg,
    input  logic                 w_fire,
    input  logic                 w_last,
    input  logic                 md_full,
    output rdmx_pkg::out_mode_t  mode,
    output rdmx_pkg::addr_t      fd_offset,
    output rdmx_pkg::addr_t      md_offset,
    output logic                 first_beat,
    output logic                 md_release,
    output logic [31:0]          frame_count,
    output logic                 eof
);
    import rdmx_pkg::*;

    // Bytes in one metadata record
    localparam int MD_BYTES = `RDMX_MD_BEATS * (`RDMX_DATA_WBITS / 8);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_FD,
        ST_MD1,
        ST_MD2,
        ST_FC
    } state_t;

    state_t      state;
    logic [15:0] beat;
    logic [31:0] pkt_cnt;
    logic [31:0] pkts_per_half;
    addr_t       fd_next;
    addr_t       md_next;
    logic        md_step;

    // ---------------------------------------------------------------------------
    // Packets per half-frame
    // ---------------------------------------------------------------------------
    // Only power-of-two packet sizes split evenly and anything else is one packet
    always_comb begin
        case (cfg.packet_size)
            16'd64:   pkts_per_half = cfg.frame_size >> 7;
            16'd128:  pkts_per_half = cfg.frame_size >> 8;
            16'd256:  pkts_per_half = cfg.frame_size >> 9;
            16'd512:  pkts_per_half = cfg.frame_size >> 10;
            16'd1024: pkts_per_half = cfg.frame_size >> 11;
            16'd2048: pkts_per_half = cfg.frame_size >> 12;
            16'd4096: pkts_per_half = cfg.frame_size >> 13;
            16'd8192: pkts_per_half = cfg.frame_size >> 14;
            default:  pkts_per_half = 32'd1;
        endcase
    end

    // Candidate ring offsets before the wrap check
    assign fd_next = fd_offset + addr_t'(cfg.packet_size);
    assign md_next = md_offset + addr_t'(MD_BYTES);

    // Metadata beats only move once the whole record is held
    assign md_step = w_fire && md_full;

    assign first_beat = (beat == 16'd0);
    assign eof        = (state == ST_FC) && w_fire;

    // Output path select
    always_comb begin
        case (state)
            ST_FD:   mode = OM_FD;
            ST_MD1:  mode = OM_MD1;
            ST_MD2:  mode = OM_MD2;
            ST_FC:   mode = OM_FC;
            default: mode = OM_IDLE;
        endcase
    end

    // ---------------------------------------------------------------------------
    // Main FSM with beat, packet and frame counters
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= ST_IDLE;
            beat        <= '0;
            pkt_cnt     <= 32'd1;
            frame_count <= 32'd1;
            fd_offset   <= '0;
            md_offset   <= '0;
            md_release  <= 1'b0;
        end else begin
            // One-cycle strobe
            md_release <= 1'b0;
            case (state)
                ST_IDLE:  state <= ST_START;
                ST_START: state <= ST_FD;
                ST_FD: begin
                    if (w_fire) begin
                        beat <= beat + 16'd1;
                        if (w_last) begin
                            beat      <= '0;
                            // Wrap before the next packet would run off the ring
                            fd_offset <= (fd_next < cfg.fd_ring.size) ? fd_next : '0;
                            if (pkt_cnt >= pkts_per_half) begin
                                state <= ST_MD1;
                            end else begin
                                pkt_cnt <= pkt_cnt + 32'd1;
                            end
                        end
                    end
                end
                ST_MD1: begin
                    if (md_step) begin
                        beat  <= 16'd1;
                        state <= ST_MD2;
                    end
                end
                ST_MD2: begin
                    if (md_step) begin
                        beat       <= '0;
                        md_release <= 1'b1;
                        md_offset  <= (md_next < cfg.md_ring.size) ? md_next : '0;
                        state      <= ST_FC;
                    end
                end
                ST_FC: begin
                    if (w_fire) begin
                        frame_count <= frame_count + 32'd1;
                        pkt_cnt     <= 32'd1;
                        state       <= ST_FD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // State register, and with it the mode, only ever carries a defined encoding
    a_state_legal: assert property (@(posedge clk) disable iff (!resetn)
        state inside {ST_IDLE, ST_START, ST_FD, ST_MD1, ST_MD2, ST_FC});

    // A stalled beat freezes everything the driver builds its beat from
    a_stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        (mode != OM_IDLE && !w_fire)
        |=> $stable({mode, fd_offset, md_offset, first_beat, frame_count}));

endmodule

// File: design/md_capture.sv
// Metadata capture, holds one two-beat record until the sequencer has written it
`timescale 1ns/1ps
`include "rdmx_settings.svh"

module md_capture (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  rdmx_pkg::data_t                       md_data,
    input  logic                                  md_valid,
    output logic                                  md_ready,
    input  logic                                  md_release,
    output logic                                  md_full,
    output rdmx_pkg::data_t [`RDMX_MD_BEATS-1:0]  md_beats
);
    import rdmx_pkg::*;

    localparam int IDX_W = (`RDMX_MD_BEATS > 1) ? $clog2(`RDMX_MD_BEATS) : 1;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`RDMX_MD_BEATS - 1);

    // Slot that the next metadata beat lands in
    logic [IDX_W-1:0] idx;
    logic             md_take;

    // Accept beats only while the record is still filling
    assign md_ready = !md_full;
    assign md_take  = md_valid && md_ready;

    // ---------------------------------------------------------------------------
    // Fill / hold control
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            idx     <= '0;
            md_full <= 1'b0;
        end else if (md_full) begin
            // Record written out, reopen for the next frame
            if (md_release) begin
                md_full <= 1'b0;
            end
        end else if (md_take) begin
            if (idx == IDX_LAST) begin
                idx     <= '0;
                md_full <= 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Beat registers
    always_ff @(posedge clk) begin
        if (md_take) begin
            md_beats[idx] <= md_data;
        end
    end

    // Held record is frozen until the sequencer releases it
    a_md_hold: assert property (@(posedge clk) disable iff (!resetn)
        (md_full && !md_release) |=> (md_full && $stable(md_beats)));

endmodule

// File: design/rdmx_pkg.sv
// Shared data, address, configuration and channel types of the shim
`include "rdmx_settings.svh"

package rdmx_pkg;

    // One beat on the write data path
    typedef logic [`RDMX_DATA_WBITS-1:0] data_t;

    // One byte-enable per data byte
    typedef logic [`RDMX_DATA_WBITS/8-1:0] strb_t;

    // Memory address or byte offset into a ring
    typedef logic [`RDMX_ADDR_WBITS-1:0] addr_t;

    // Geometry of one circular ring
    typedef struct packed {
        addr_t base;
        addr_t size;
    } ring_t;

    // Static configuration, held while out of reset
    typedef struct packed {
        logic [15:0] packet_size;  // bytes per packet
        logic [31:0] frame_size;   // bytes per full frame
        ring_t       fd_ring;
        ring_t       md_ring;
        addr_t       fc_addr;
    } shim_cfg_t;

    // Frame-data stream beat
    typedef struct packed {
        data_t data;
        logic  last;
    } fd_beat_t;

    // Write-address announcement, len is beats minus one
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } aw_req_t;

    // Write-data beat
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    // Source currently steered onto the write channels
    typedef enum logic [2:0] {
        OM_IDLE = 3'd0,
        OM_FD   = 3'd1,
        OM_MD1  = 3'd2,
        OM_MD2  = 3'd3,
        OM_FC   = 3'd4
    } out_mode_t;

endpackage

// File: design/rdmx_settings.svh
// Sizing macros for the frame-streaming shim data path
`ifndef RDMX_SETTINGS_SVH
`define RDMX_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Data path geometry
// ---------------------------------------------------------------------------

// Width of one write data beat, in bits
`define RDMX_DATA_WBITS 64

// Width of a memory address or byte offset
`define RDMX_ADDR_WBITS 64

// Beats in one metadata record (16 bytes at 64 bits)
`define RDMX_MD_BEATS 2

// Bytes enabled in the frame-counter beat
`define RDMX_FC_BYTES 4

`endif
